//--- logic/rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] word_t;    // data word or byte address
    typedef logic [4:0]  reg_idx_t; // x0 .. x31
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [2:0]  br_op_t;

    localparam int num_regs = 32;
    localparam int shamt_w  = 5;                   // shift amount bits
    localparam logic [6:0] funct7_alt = 7'b0100000; // sub / sra / srai

    // major opcodes of the kept groups
    localparam opcode_t opc_op     = 7'b0110011;
    localparam opcode_t opc_op_imm = 7'b0010011;
    localparam opcode_t opc_lui    = 7'b0110111;
    localparam opcode_t opc_auipc  = 7'b0010111;
    localparam opcode_t opc_jal    = 7'b1101111;
    localparam opcode_t opc_jalr   = 7'b1100111;
    localparam opcode_t opc_branch = 7'b1100011;

    // alu functions, shared by op and op_imm
    localparam funct3_t f3_add_sub = 3'b000;
    localparam funct3_t f3_sll     = 3'b001;
    localparam funct3_t f3_slt     = 3'b010;
    localparam funct3_t f3_sltu    = 3'b011;
    localparam funct3_t f3_xor     = 3'b100;
    localparam funct3_t f3_srl_sra = 3'b101;
    localparam funct3_t f3_or      = 3'b110;
    localparam funct3_t f3_and     = 3'b111;

    // branch functions
    localparam funct3_t f3_beq  = 3'b000;
    localparam funct3_t f3_bne  = 3'b001;
    localparam funct3_t f3_blt  = 3'b100;
    localparam funct3_t f3_bge  = 3'b101;
    localparam funct3_t f3_bltu = 3'b110;
    localparam funct3_t f3_bgeu = 3'b111;
    localparam funct3_t f3_jalr = 3'b000;

    // alu operation picked by decode
    localparam alu_op_t alu_nop    = 4'd0;
    localparam alu_op_t alu_add    = 4'd1;
    localparam alu_op_t alu_sub    = 4'd2;
    localparam alu_op_t alu_slt    = 4'd3;
    localparam alu_op_t alu_sltu   = 4'd4;
    localparam alu_op_t alu_and    = 4'd5;
    localparam alu_op_t alu_or     = 4'd6;
    localparam alu_op_t alu_xor    = 4'd7;
    localparam alu_op_t alu_sll    = 4'd8;
    localparam alu_op_t alu_srl    = 4'd9;
    localparam alu_op_t alu_sra    = 4'd10;
    localparam alu_op_t alu_pass_b = 4'd11; // lui

    // branch kind
    localparam br_op_t br_none = 3'd0;
    localparam br_op_t br_eq   = 3'd1;
    localparam br_op_t br_ne   = 3'd2;
    localparam br_op_t br_lt   = 3'd3;
    localparam br_op_t br_ge   = 3'd4;
    localparam br_op_t br_ltu  = 3'd5;
    localparam br_op_t br_geu  = 3'd6;
    localparam br_op_t br_jump = 3'd7; // jal and jalr

endpackage

//--- logic/rv_result.sv
`timescale 1ns/100ps

module rv_result (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             wb_valid,
    input  rv_pkg::reg_idx_t wb_rd,
    input  rv_pkg::word_t    wb_data,
    input  rv_pkg::reg_idx_t rs1_addr,
    input  rv_pkg::reg_idx_t rs2_addr,
    output rv_pkg::word_t    rs1_data,
    output rv_pkg::word_t    rs2_data
);

    rv_pkg::word_t regs [1:rv_pkg::num_regs-1]; // x0 has no storage

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < rv_pkg::num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // asynchronous reads, x0 always reads zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    a_write_lands: assert property (@(posedge clk) disable iff (!arst_n)
        (wb_valid && wb_rd != '0) |=> (regs[$past(wb_rd)] == $past(wb_data)));

endmodule

//--- logic/rv_decode.sv
`timescale 1ns/100ps

module rv_decode (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             insn_valid,
    input  rv_pkg::word_t    insn,
    input  rv_pkg::word_t    pc,
    output rv_pkg::reg_idx_t rs1_addr,
    output rv_pkg::reg_idx_t rs2_addr,
    input  rv_pkg::word_t    rs1_data,
    input  rv_pkg::word_t    rs2_data,
    input  logic             ex_fwd_valid,
    input  rv_pkg::reg_idx_t ex_fwd_rd,
    input  rv_pkg::word_t    ex_fwd_data,
    input  logic             wb_valid,
    input  rv_pkg::reg_idx_t wb_rd,
    input  rv_pkg::word_t    wb_data,
    output logic             id_valid,
    output rv_pkg::alu_op_t  id_alu_op,
    output rv_pkg::br_op_t   id_br_op,
    output rv_pkg::word_t    id_opa,
    output rv_pkg::word_t    id_opb,
    output rv_pkg::word_t    id_imm,
    output rv_pkg::word_t    id_pc,
    output rv_pkg::reg_idx_t id_rd,
    output logic             id_we,
    output logic             id_undef
);

    rv_pkg::opcode_t  opcode;
    rv_pkg::funct3_t  funct3;
    logic [6:0]       funct7;
    rv_pkg::reg_idx_t rd;
    rv_pkg::word_t    imm_i, imm_u, imm_b, imm_j;
    rv_pkg::word_t    rs1_val, rs2_val; // operands after forwarding

    rv_pkg::alu_op_t  dec_alu_op;
    rv_pkg::br_op_t   dec_br_op;
    rv_pkg::word_t    dec_opa, dec_opb, dec_imm;
    logic             dec_we, dec_undef;

    assign opcode   = insn[6:0];
    assign rd       = insn[11:7];
    assign funct3   = insn[14:12];
    assign rs1_addr = insn[19:15];
    assign rs2_addr = insn[24:20];
    assign funct7   = insn[31:25];

    assign imm_i = {{20{insn[31]}}, insn[31:20]};
    assign imm_u = {insn[31:12], 12'b0};
    assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

    // newest value wins: execute result, then write-back regs, then the register file
    assign rs1_val = (ex_fwd_valid && ex_fwd_rd == rs1_addr && rs1_addr != '0) ? ex_fwd_data :
                     (wb_valid && wb_rd == rs1_addr && rs1_addr != '0)         ? wb_data     :
                                                                                 rs1_data;
    assign rs2_val = (ex_fwd_valid && ex_fwd_rd == rs2_addr && rs2_addr != '0) ? ex_fwd_data :
                     (wb_valid && wb_rd == rs2_addr && rs2_addr != '0)         ? wb_data     :
                                                                                 rs2_data;

    always_comb begin
        dec_alu_op = rv_pkg::alu_nop;
        dec_br_op  = rv_pkg::br_none;
        dec_we     = 1'b0;
        dec_undef  = 1'b0;
        dec_opa    = rs1_val;
        dec_opb    = rs2_val;
        dec_imm    = imm_i;
        case (opcode)
            rv_pkg::opc_op: begin
                dec_we = 1'b1;
                if (funct7 == 7'b0) begin
                    case (funct3)
                        rv_pkg::f3_add_sub: dec_alu_op = rv_pkg::alu_add;
                        rv_pkg::f3_sll:     dec_alu_op = rv_pkg::alu_sll;
                        rv_pkg::f3_slt:     dec_alu_op = rv_pkg::alu_slt;
                        rv_pkg::f3_sltu:    dec_alu_op = rv_pkg::alu_sltu;
                        rv_pkg::f3_xor:     dec_alu_op = rv_pkg::alu_xor;
                        rv_pkg::f3_srl_sra: dec_alu_op = rv_pkg::alu_srl;
                        rv_pkg::f3_or:      dec_alu_op = rv_pkg::alu_or;
                        default:            dec_alu_op = rv_pkg::alu_and;
                    endcase
                end else if (funct7 == rv_pkg::funct7_alt && funct3 == rv_pkg::f3_add_sub) begin
                    dec_alu_op = rv_pkg::alu_sub;
                end else if (funct7 == rv_pkg::funct7_alt && funct3 == rv_pkg::f3_srl_sra) begin
                    dec_alu_op = rv_pkg::alu_sra;
                end else begin
                    dec_undef = 1'b1;
                end
            end
            rv_pkg::opc_op_imm: begin
                dec_we  = 1'b1;
                dec_opb = imm_i; // shifts only look at the low bits
                case (funct3)
                    rv_pkg::f3_add_sub: dec_alu_op = rv_pkg::alu_add;
                    rv_pkg::f3_slt:     dec_alu_op = rv_pkg::alu_slt;
                    rv_pkg::f3_sltu:    dec_alu_op = rv_pkg::alu_sltu;
                    rv_pkg::f3_xor:     dec_alu_op = rv_pkg::alu_xor;
                    rv_pkg::f3_or:      dec_alu_op = rv_pkg::alu_or;
                    rv_pkg::f3_and:     dec_alu_op = rv_pkg::alu_and;
                    rv_pkg::f3_sll: begin
                        dec_alu_op = rv_pkg::alu_sll;
                        dec_undef  = (funct7 != 7'b0);
                    end
                    default: begin
                        if (funct7 == 7'b0)
                            dec_alu_op = rv_pkg::alu_srl;
                        else if (funct7 == rv_pkg::funct7_alt)
                            dec_alu_op = rv_pkg::alu_sra;
                        else
                            dec_undef = 1'b1;
                    end
                endcase
            end
            rv_pkg::opc_lui: begin
                dec_we     = 1'b1;
                dec_alu_op = rv_pkg::alu_pass_b;
                dec_opb    = imm_u;
                dec_imm    = imm_u;
            end
            rv_pkg::opc_auipc: begin
                dec_we     = 1'b1;
                dec_alu_op = rv_pkg::alu_add;
                dec_opa    = pc;
                dec_opb    = imm_u;
                dec_imm    = imm_u;
            end
            rv_pkg::opc_jal: begin
                dec_we     = 1'b1;
                dec_alu_op = rv_pkg::alu_add; // link = pc + 4
                dec_br_op  = rv_pkg::br_jump;
                dec_opa    = pc;              // jump base
                dec_opb    = 32'd4;
                dec_imm    = imm_j;
            end
            rv_pkg::opc_jalr: begin
                dec_we     = 1'b1;
                dec_alu_op = rv_pkg::alu_add;
                dec_br_op  = rv_pkg::br_jump;
                dec_opb    = 32'd4;           // opa keeps rs1 as the jump base
                dec_undef  = (funct3 != rv_pkg::f3_jalr);
            end
            rv_pkg::opc_branch: begin
                dec_imm = imm_b;
                case (funct3)
                    rv_pkg::f3_beq:  dec_br_op = rv_pkg::br_eq;
                    rv_pkg::f3_bne:  dec_br_op = rv_pkg::br_ne;
                    rv_pkg::f3_blt:  dec_br_op = rv_pkg::br_lt;
                    rv_pkg::f3_bge:  dec_br_op = rv_pkg::br_ge;
                    rv_pkg::f3_bltu: dec_br_op = rv_pkg::br_ltu;
                    rv_pkg::f3_bgeu: dec_br_op = rv_pkg::br_geu;
                    default:         dec_undef = 1'b1;
                endcase
            end
            default: dec_undef = 1'b1;
        endcase
        if (dec_undef) begin // an unknown encoding does nothing
            dec_we     = 1'b0;
            dec_alu_op = rv_pkg::alu_nop;
            dec_br_op  = rv_pkg::br_none;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_valid  <= 1'b0;
            id_we     <= 1'b0;
            id_undef  <= 1'b0;
            id_alu_op <= rv_pkg::alu_nop;
            id_br_op  <= rv_pkg::br_none;
            id_opa    <= '0;
            id_opb    <= '0;
            id_imm    <= '0;
            id_pc     <= '0;
            id_rd     <= '0;
        end else begin
            id_valid  <= insn_valid;
            id_we     <= insn_valid && dec_we;
            id_undef  <= insn_valid && dec_undef;
            id_alu_op <= dec_alu_op;
            id_br_op  <= dec_br_op;
            id_opa    <= dec_opa;
            id_opb    <= dec_opb;
            id_imm    <= dec_imm;
            id_pc     <= pc;
            id_rd     <= rd;
        end
    end

    // a rejected instruction must never reach the register file
    a_undef_no_we: assert property (@(posedge clk) disable iff (!arst_n) !(id_undef && id_we));

endmodule

//--- logic/rv_execute.sv
`timescale 1ns/100ps

module rv_execute (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             id_valid,
    input  rv_pkg::alu_op_t  id_alu_op,
    input  rv_pkg::br_op_t   id_br_op,
    input  rv_pkg::word_t    id_opa,
    input  rv_pkg::word_t    id_opb,
    input  rv_pkg::word_t    id_imm,
    input  rv_pkg::word_t    id_pc,
    input  rv_pkg::reg_idx_t id_rd,
    input  logic             id_we,
    input  logic             id_undef,
    output logic             ex_fwd_valid,
    output rv_pkg::reg_idx_t ex_fwd_rd,
    output rv_pkg::word_t    ex_fwd_data,
    output logic             wb_valid,
    output rv_pkg::reg_idx_t wb_rd,
    output rv_pkg::word_t    wb_data,
    output logic             br_valid,
    output logic             br_taken,
    output rv_pkg::word_t    br_addr,
    output logic             undef_insn
);

    logic                       is_jump;
    rv_pkg::word_t              alu_a;
    logic [rv_pkg::shamt_w-1:0] shamt;
    rv_pkg::word_t              ex_result;
    rv_pkg::word_t              tgt_sum, tgt;
    logic                       cond;

    assign is_jump = (id_br_op == rv_pkg::br_jump);
    assign alu_a   = is_jump ? id_pc : id_opa; // jumps link pc + 4, opa holds the base
    assign shamt   = id_opb[rv_pkg::shamt_w-1:0];

    always_comb begin
        case (id_alu_op)
            rv_pkg::alu_add:    ex_result = alu_a + id_opb;
            rv_pkg::alu_sub:    ex_result = alu_a - id_opb;
            rv_pkg::alu_slt:    ex_result = {31'b0, $signed(alu_a) < $signed(id_opb)};
            rv_pkg::alu_sltu:   ex_result = {31'b0, alu_a < id_opb};
            rv_pkg::alu_and:    ex_result = alu_a & id_opb;
            rv_pkg::alu_or:     ex_result = alu_a | id_opb;
            rv_pkg::alu_xor:    ex_result = alu_a ^ id_opb;
            rv_pkg::alu_sll:    ex_result = alu_a << shamt;
            rv_pkg::alu_srl:    ex_result = alu_a >> shamt;
            rv_pkg::alu_sra:    ex_result = $signed(alu_a) >>> shamt;
            rv_pkg::alu_pass_b: ex_result = id_opb;
            default:            ex_result = '0; // nop
        endcase
    end

    always_comb begin
        case (id_br_op)
            rv_pkg::br_eq:   cond = (id_opa == id_opb);
            rv_pkg::br_ne:   cond = (id_opa != id_opb);
            rv_pkg::br_lt:   cond = ($signed(id_opa) < $signed(id_opb));
            rv_pkg::br_ge:   cond = ($signed(id_opa) >= $signed(id_opb));
            rv_pkg::br_ltu:  cond = (id_opa < id_opb);
            rv_pkg::br_geu:  cond = (id_opa >= id_opb);
            rv_pkg::br_jump: cond = 1'b1;
            default:         cond = 1'b0;
        endcase
    end

    // jal base is pc and its offset is even, so clearing bit 0 only matters for jalr
    assign tgt_sum = (is_jump ? id_opa : id_pc) + id_imm;
    assign tgt     = is_jump ? {tgt_sum[31:1], 1'b0} : tgt_sum;

    assign ex_fwd_valid = id_valid && id_we;
    assign ex_fwd_rd    = id_rd;
    assign ex_fwd_data  = ex_result;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid   <= 1'b0;
            wb_rd      <= '0;
            wb_data    <= '0;
            br_valid   <= 1'b0;
            br_taken   <= 1'b0;
            br_addr    <= '0;
            undef_insn <= 1'b0;
        end else begin
            wb_valid   <= ex_fwd_valid;
            wb_rd      <= id_rd;
            wb_data    <= ex_result;
            br_valid   <= id_valid && (id_br_op != rv_pkg::br_none);
            br_taken   <= id_valid && cond;
            br_addr    <= tgt;
            undef_insn <= id_valid && id_undef;
        end
    end

    a_taken_has_valid: assert property (@(posedge clk) disable iff (!arst_n)
        br_taken |-> br_valid);

endmodule

//--- logic/rv_int_core.sv
`timescale 1ns/100ps

module rv_int_core (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             insn_valid,
    input  rv_pkg::word_t    insn,
    input  rv_pkg::word_t    pc,
    output logic             wb_valid,
    output rv_pkg::reg_idx_t wb_rd,
    output rv_pkg::word_t    wb_data,
    output logic             br_valid,
    output logic             br_taken,
    output rv_pkg::word_t    br_addr,
    output logic             undef_insn
);

    rv_pkg::reg_idx_t rs1_addr, rs2_addr;
    rv_pkg::word_t    rs1_data, rs2_data;

    // decode to execute
    logic             id_valid;
    rv_pkg::alu_op_t  id_alu_op;
    rv_pkg::br_op_t   id_br_op;
    rv_pkg::word_t    id_opa, id_opb, id_imm, id_pc;
    rv_pkg::reg_idx_t id_rd;
    logic             id_we, id_undef;

    // execute result fed back for forwarding
    logic             ex_fwd_valid;
    rv_pkg::reg_idx_t ex_fwd_rd;
    rv_pkg::word_t    ex_fwd_data;

    rv_decode u_rv_decode (
        .clk, .arst_n, .insn_valid, .insn, .pc,
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .ex_fwd_valid, .ex_fwd_rd, .ex_fwd_data,
        .wb_valid, .wb_rd, .wb_data,
        .id_valid, .id_alu_op, .id_br_op, .id_opa, .id_opb,
        .id_imm, .id_pc, .id_rd, .id_we, .id_undef
    );

    rv_execute u_rv_execute (
        .clk, .arst_n,
        .id_valid, .id_alu_op, .id_br_op, .id_opa, .id_opb,
        .id_imm, .id_pc, .id_rd, .id_we, .id_undef,
        .ex_fwd_valid, .ex_fwd_rd, .ex_fwd_data,
        .wb_valid, .wb_rd, .wb_data,
        .br_valid, .br_taken, .br_addr, .undef_insn
    );

    rv_result u_rv_result (
        .clk, .arst_n,
        .wb_valid, .wb_rd, .wb_data,
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data
    );

endmodule

//--- tb/rv_model.svh
`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

// expected outputs of one issue slot
typedef struct packed {
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        br_valid;
    logic        br_taken;
    logic [31:0] br_addr;
    logic        undef;
} expect_t;

logic [31:0] shadow [0:31]; // architectural registers, updated in program order

function automatic logic [31:0] branch_word(input logic [31:0] off, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::opc_branch};
endfunction

function automatic logic [31:0] jal_word(input logic [31:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::opc_jal};
endfunction

// rv32i alu semantics, alt picks sub and sra
function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
    logic signed [31:0] sa;
    sa = a;
    case (f3)
        3'd0: return alt ? a - b : a + b;
        3'd1: return a << b[4:0];
        3'd2: return {31'b0, $signed(a) < $signed(b)};
        3'd3: return {31'b0, a < b};
        3'd4: return a ^ b;
        3'd5: begin
            if (alt)
                return sa >>> b[4:0];
            return a >> b[4:0];
        end
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

// imm is the sign-extended immediate that the generator put into the word
function automatic expect_t run_model(input logic [31:0] word, input logic [31:0] pc,
                                      input logic [31:0] imm);
    expect_t     e;
    logic [31:0] a;
    logic [31:0] b;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        ok;
    e       = '0;
    a       = shadow[word[19:15]];
    b       = shadow[word[24:20]];
    f3      = word[14:12];
    f7      = word[31:25];
    ok      = 1'b1;
    e.wb_rd = word[11:7];
    case (word[6:0])
        rv_pkg::opc_op: begin
            ok = (f7 == 7'd0) || (f7 == rv_pkg::funct7_alt && (f3 == 3'd0 || f3 == 3'd5));
            e.wb_valid = 1'b1;
            e.wb_data  = alu_result(f3, f7[5], a, b);
        end
        rv_pkg::opc_op_imm: begin
            if (f3 == 3'd1)
                ok = (f7 == 7'd0);
            if (f3 == 3'd5)
                ok = (f7 == 7'd0) || (f7 == rv_pkg::funct7_alt);
            e.wb_valid = 1'b1;
            e.wb_data  = alu_result(f3, f3 == 3'd5 && f7[5], a, imm); // addi has no sub
        end
        rv_pkg::opc_lui: begin
            e.wb_valid = 1'b1;
            e.wb_data  = imm;
        end
        rv_pkg::opc_auipc: begin
            e.wb_valid = 1'b1;
            e.wb_data  = pc + imm;
        end
        rv_pkg::opc_jal, rv_pkg::opc_jalr: begin
            ok         = (word[6:0] == rv_pkg::opc_jal) || (f3 == 3'd0);
            e.wb_valid = 1'b1;
            e.wb_data  = pc + 32'd4; // link
            e.br_valid = 1'b1;
            e.br_taken = 1'b1;
            if (word[6:0] == rv_pkg::opc_jal)
                e.br_addr = pc + imm;
            else
                e.br_addr = (a + imm) & ~32'd1;
        end
        rv_pkg::opc_branch: begin
            e.br_valid = 1'b1;
            e.br_addr  = pc + imm;
            case (f3)
                3'd0: e.br_taken = (a == b);
                3'd1: e.br_taken = (a != b);
                3'd4: e.br_taken = ($signed(a) < $signed(b));
                3'd5: e.br_taken = ($signed(a) >= $signed(b));
                3'd6: e.br_taken = (a < b);
                3'd7: e.br_taken = (a >= b);
                default: ok = 1'b0;
            endcase
        end
        default: ok = 1'b0;
    endcase
    if (!ok) begin
        e       = '0;
        e.undef = 1'b1; // nothing written, registers untouched
    end else if (e.wb_valid && e.wb_rd != 5'd0) begin
        shadow[e.wb_rd] = e.wb_data;
    end
    return e;
endfunction

`endif

//--- tb/tb_rv_int_core.sv
`timescale 1ns/100ps

module tb_rv_int_core;

    localparam int num_slots = 600; // issue slots, gaps included

    logic             clk;
    logic             arst_n;
    logic             insn_valid;
    rv_pkg::word_t    insn;
    rv_pkg::word_t    pc;
    logic             wb_valid;
    rv_pkg::reg_idx_t wb_rd;
    rv_pkg::word_t    wb_data;
    logic             br_valid;
    logic             br_taken;
    rv_pkg::word_t    br_addr;
    logic             undef_insn;

    `include "rv_model.svh"

    expect_t want;      // outputs expected in the current cycle
    expect_t want_q[$]; // two slots between issue and output

    rv_int_core u_rv_int_core (
        .clk, .arst_n, .insn_valid, .insn, .pc,
        .wb_valid, .wb_rd, .wb_data,
        .br_valid, .br_taken, .br_addr, .undef_insn
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp_val);
        $display("ERR %s got %h expected %h", name, got, exp_val);
        $display("Testbench failed");
        $fatal(1, "mismatch on %s", name);
    endtask

    task automatic make_insn(output logic [31:0] word, output logic [31:0] imm);
        logic [31:0] r;
        logic [31:0] s;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        r   = $urandom;
        s   = $urandom;
        rd  = 5'($urandom % 4); // few registers, so dependences are common
        rs1 = 5'($urandom % 4);
        rs2 = 5'($urandom % 4);
        f3  = r[14:12];
        f7  = (r[30] && (f3 == 3'd0 || f3 == 3'd5)) ? rv_pkg::funct7_alt : 7'd0;
        imm = {{20{s[11]}}, s[11:0]};
        case ($urandom % 10)
            0, 1: word = {f7, rs2, rs1, f3, rd, rv_pkg::opc_op};
            2, 3: begin
                if (f3 == 3'd1 || f3 == 3'd5)
                    imm = {20'd0, f7, s[4:0]}; // shift amount with the funct7 on top
                word = {imm[11:0], rs1, f3, rd, rv_pkg::opc_op_imm};
            end
            4, 5: begin
                imm  = {s[31:12], 12'd0};
                word = {s[31:12], rd, r[0] ? rv_pkg::opc_lui : rv_pkg::opc_auipc};
            end
            6: begin
                imm  = {{11{s[20]}}, s[20:1], 1'b0};
                word = jal_word(imm, rd);
            end
            7: word = {imm[11:0], rs1, 3'd0, rd, rv_pkg::opc_jalr};
            8: begin
                if (f3[2:1] == 2'b01)
                    f3[2] = 1'b1; // funct3 2 and 3 are no branches
                imm  = {{19{s[12]}}, s[12:1], 1'b0};
                word = branch_word(imm, rs2, rs1, f3);
            end
            default: begin
                case (r[1:0])
                    2'd0: word = {r[31:7], 7'b0000011};                        // load
                    2'd1: word = {7'b0000001, rs2, rs1, f3, rd, rv_pkg::opc_op}; // mul group
                    2'd2: word = branch_word(imm, rs2, rs1, 3'd2);
                    default: word = {imm[11:0], rs1, 3'd1, rd, rv_pkg::opc_jalr};
                endcase
            end
        endcase
    endtask

    initial begin
        expect_t     idle;
        logic [31:0] word;
        logic [31:0] imm;
        logic [31:0] r;
        void'($urandom(32'ha264));
        arst_n     = 1'b0;
        insn_valid = 1'b0;
        insn       = '0;
        pc         = '0;
        idle       = '0;
        want       = '0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        want_q.push_back(idle);
        want_q.push_back(idle);
        repeat (2) @(posedge clk);
        #1 arst_n = 1'b1;
        for (int n = 0; n < num_slots + 3; n++) begin
            @(posedge clk);
            #1;
            if (n < num_slots && $urandom % 4 != 0) begin
                make_insn(word, imm);
                r          = $urandom;
                insn       = word;
                pc         = {r[31:2], 2'b00};
                insn_valid = 1'b1;
                want_q.push_back(run_model(word, {r[31:2], 2'b00}, imm));
            end else begin
                insn       = $urandom; // ignored without the strobe
                insn_valid = 1'b0;
                want_q.push_back(idle);
            end
            want = want_q.pop_front();
        end
        $display("Testbench passed");
        $finish;
    end

    initial begin
        #((num_slots + 20) * 8);
        $display("watchdog expired before all instructions were checked");
        $display("Testbench failed");
        $fatal(1, "timeout");
    end

    // outputs settle at the rising edge, so compare at the falling one
    a_wb_valid: assert property (@(negedge clk) disable iff (!arst_n)
        wb_valid == want.wb_valid)
        else report_mismatch("wb_valid", 32'(wb_valid), 32'(want.wb_valid));
    a_wb_rd: assert property (@(negedge clk) disable iff (!arst_n)
        wb_valid |-> wb_rd == want.wb_rd)
        else report_mismatch("wb_rd", 32'(wb_rd), 32'(want.wb_rd));
    a_wb_data: assert property (@(negedge clk) disable iff (!arst_n)
        wb_valid |-> wb_data == want.wb_data)
        else report_mismatch("wb_data", wb_data, want.wb_data);
    a_br_valid: assert property (@(negedge clk) disable iff (!arst_n)
        br_valid == want.br_valid)
        else report_mismatch("br_valid", 32'(br_valid), 32'(want.br_valid));
    a_br_taken: assert property (@(negedge clk) disable iff (!arst_n)
        br_taken == want.br_taken)
        else report_mismatch("br_taken", 32'(br_taken), 32'(want.br_taken));
    a_br_addr: assert property (@(negedge clk) disable iff (!arst_n)
        br_valid |-> br_addr == want.br_addr)
        else report_mismatch("br_addr", br_addr, want.br_addr);
    a_undef: assert property (@(negedge clk) disable iff (!arst_n)
        undef_insn == want.undef)
        else report_mismatch("undef_insn", 32'(undef_insn), 32'(want.undef));

endmodule

//--- list.f
+incdir+tb
logic/rv_pkg.sv
logic/rv_result.sv
logic/rv_decode.sv
logic/rv_execute.sv
logic/rv_int_core.sv
tb/tb_rv_int_core.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps -j 0 \
    --top-module tb_rv_int_core -f list.f
./obj_dir/Vtb_rv_int_core | tee sim.log

if grep -q "^Testbench passed$" sim.log; then
    echo "simulation PASS"
else
    echo "simulation FAIL"
    exit 1
fi
